//--- all.f
logic/cpu_isa_pkg.sv
logic/cpu_control_pkg.sv
logic/d_format_decoder.sv
logic/i_format_decoder.sv
logic/control_word_select.sv
logic/register_file.sv
logic/alu.sv
logic/data_bus_unit.sv
logic/datapath_core.sv
bench/clock_gen.sv
bench/datapath_core_asserts.sv
bench/tb_datapath_core.sv

//--- bench/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // Four rising edges in reset, release on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

//--- bench/datapath_core_asserts.sv
module datapath_core_asserts #(
    parameter int DATA_W = 64
) (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           illegal,
    input logic                           status_ld,  // Gated load strobe
    input cpu_control_pkg::control_word_t cw_out,
    input logic [DATA_W-1:0]              data_bus,
    input cpu_control_pkg::status_t       status
);
    timeunit 1ns;
    timeprecision 100ps;

    // Unknown opcode must never carry a write
    illegal_no_writes: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> !(cw_out.rf_w || cw_out.ram_w || cw_out.status_ld))
        else $error("write enable set in control word of an illegal opcode");

    // Idle bus reads as zero
    idle_bus_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !(cw_out.alu_en || cw_out.rf_b_en || cw_out.ram_en) |-> (data_bus == '0))
        else $error("data bus nonzero with no source enabled");

    // NZCV only moves on a load
    status_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !status_ld |=> $stable(status))
        else $error("status changed without a status load");
endmodule

bind datapath_core datapath_core_asserts #(.DATA_W(DATA_W)) i_datapath_core_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .illegal   (illegal),
    .status_ld (status_ld_q),
    .cw_out    (cw_out),
    .data_bus  (data_bus),
    .status    (status)
);

//--- bench/tb_datapath_core.sv
module tb_datapath_core;
    timeunit 1ns;
    timeprecision 100ps;

    logic                           clk;
    logic                           rst_n;
    cpu_isa_pkg::instr_t            instr;
    logic                           instr_valid;
    logic [63:0]                    data_bus;
    cpu_control_pkg::status_t       status;
    logic                           illegal;
    cpu_control_pkg::control_word_t cw_out;

    logic [63:0] model [32];   // Expected register contents, x31 stays zero
    logic [3:0]  exp_status;   // Expected NZCV
    logic [8:0]  store_off;    // Offset of the first store, reused later
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    string       test_name;

    clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

    datapath_core #(.DATA_W(64), .RAM_WORDS(64)) i_datapath_core (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
        .data_bus(data_bus), .status(status), .illegal(illegal), .cw_out(cw_out)
    );

    // Hard limit on the whole run
    initial begin
        #50us;
        $display("timeout, run exceeded its time limit");
        $display("Simulation failed");
        $finish;
    end

    function automatic cpu_isa_pkg::instr_t encode_i(input logic [9:0] opc,
            input logic [11:0] imm, input logic [4:0] rn, input logic [4:0] rd);
        return {opc, imm, rn, rd};                     // imm12 spans op[0], imm9, op2
    endfunction

    function automatic cpu_isa_pkg::instr_t encode_d(input logic [10:0] op,
            input logic [8:0] off, input logic [4:0] rn, input logic [4:0] rt);
        return {op, off, 2'b00, rn, rt};
    endfunction

    // Bus sources and write strobes, msb first
    // alu_en, rf_b_en, rf_w, ram_en, ram_w, status_ld
    function automatic logic [5:0] enables(input cpu_control_pkg::control_word_t cw);
        return {cw.alu_en, cw.rf_b_en, cw.rf_w, cw.ram_en, cw.ram_w, cw.status_ld};
    endfunction

    task automatic next_negedge();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 4 && !seen; n++) begin   // At most two clock toggles needed
            @(clk);
            seen = (clk == 1'b0);
        end
        if (!seen) begin
            $display("timeout, no falling clock edge seen");
            $display("Simulation failed");
            $finish;
        end
    endtask

    // Drive on the falling edge, settle before sampling
    task automatic run_instr(input cpu_isa_pkg::instr_t word, input logic valid);
        next_negedge();
        instr       = word;
        instr_valid = valid;
        #2;
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            failed_tests++;
        end
    endtask

    // Immediate op with bus check, model follows
    task automatic exec_imm(input logic [9:0] opc, input logic [4:0] rd, input logic [4:0] rn,
            input logic [11:0] imm, input logic [63:0] exp);
        logic set_flags;
        set_flags = (opc == cpu_isa_pkg::OP_ADDIS) || (opc == cpu_isa_pkg::OP_SUBIS);
        run_instr(encode_i(opc, imm, rn, rd), 1'b1);
        check("data_bus", exp, data_bus);
        check("illegal", 64'd0, {63'd0, illegal});
        // ALU onto bus, Rd written, flags only for the S forms
        check("cw_out enables", {58'd0, 5'b10100, set_flags}, {58'd0, enables(cw_out)});
        if (rd != 5'd31) model[rd] = exp;
    endtask

    // ORRI into XZR shows a register with no side effect
    task automatic read_reg(input logic [4:0] r);
        run_instr(encode_i(cpu_isa_pkg::OP_ORRI, 12'd0, r, 5'd31), 1'b1);
        check($sformatf("x%0d", r), model[r], data_bus);
    endtask

    task automatic test_addi();
        logic [11:0] imm;
        begin_test("addi");
        for (int r = 1; r <= 4; r++) begin
            imm = 12'($urandom);
            exec_imm(cpu_isa_pkg::OP_ADDI, 5'(r), 5'd31, imm, {52'd0, imm});
        end
        for (int r = 1; r <= 4; r++) read_reg(5'(r));
        end_test();
    endtask

    task automatic test_flags();
        logic [11:0] base_val;
        logic [11:0] larger;
        logic [11:0] mask;
        begin_test("flags");
        base_val = 12'($urandom_range(1, 2000));
        larger   = base_val + 12'($urandom_range(1, 2000));
        mask     = 12'($urandom);
        exec_imm(cpu_isa_pkg::OP_ADDI, 5'd5, 5'd31, base_val, {52'd0, base_val});
        exec_imm(cpu_isa_pkg::OP_SUBIS, 5'd6, 5'd5, larger, model[5] - {52'd0, larger});
        exec_imm(cpu_isa_pkg::OP_SUBIS, 5'd7, 5'd5, base_val, 64'd0);
        check("status", 64'b1000, {60'd0, status});        // Borrow, so n and no c
        exec_imm(cpu_isa_pkg::OP_ANDI, 5'd8, 5'd5, mask, model[5] & {52'd0, mask});
        check("status", 64'b0110, {60'd0, status});        // Equal operands, z and c
        exec_imm(cpu_isa_pkg::OP_ADDIS, 5'd9, 5'd5, larger, model[5] + {52'd0, larger});
        check("status", 64'b0110, {60'd0, status});        // ANDI left them alone
        read_reg(5'd9);
        exp_status = 4'b0000;                              // Small positive sum
        check("status", {60'd0, exp_status}, {60'd0, status});
        end_test();
    endtask

    task automatic test_logic();
        logic [11:0] imm;
        logic [4:0]  src [3];
        begin_test("logic");
        src = '{5'd6, 5'd1, 5'd9};
        foreach (src[i]) begin
            imm = 12'($urandom);
            exec_imm(cpu_isa_pkg::OP_ANDI, 5'd10, src[i], imm, model[src[i]] & {52'd0, imm});
            exec_imm(cpu_isa_pkg::OP_ORRI, 5'd11, src[i], imm, model[src[i]] | {52'd0, imm});
            exec_imm(cpu_isa_pkg::OP_EORI, 5'd12, src[i], imm, model[src[i]] ^ {52'd0, imm});
        end
        read_reg(5'd12);
        end_test();
    endtask

    task automatic test_load_store();
        logic [11:0] base;
        begin_test("load_store");
        base      = 12'($urandom);
        store_off = 9'($urandom);
        exec_imm(cpu_isa_pkg::OP_ADDI, 5'd13, 5'd31, base, {52'd0, base});
        run_instr(encode_d(cpu_isa_pkg::OP_STUR, store_off, 5'd13, 5'd6), 1'b1);
        check("store data_bus", model[6], data_bus);
        check("store enables", {58'd0, 6'b010110}, {58'd0, enables(cw_out)});  // Rt to RAM
        // Address 8 bytes away lands in the neighbouring word
        run_instr(encode_d(cpu_isa_pkg::OP_STUR, store_off ^ 9'h008, 5'd13, 5'd9), 1'b1);
        check("store data_bus", model[9], data_bus);
        run_instr(encode_d(cpu_isa_pkg::OP_LDUR, store_off, 5'd13, 5'd14), 1'b1);
        check("load data_bus", model[6], data_bus);
        check("load enables", {58'd0, 6'b001100}, {58'd0, enables(cw_out)});   // RAM to Rt
        model[14] = model[6];
        read_reg(5'd14);
        end_test();
    endtask

    task automatic test_zero_reg();
        logic [11:0] imm;
        begin_test("zero_reg");
        imm = 12'($urandom_range(1, 4095));
        exec_imm(cpu_isa_pkg::OP_ADDI, 5'd31, 5'd31, imm, {52'd0, imm});  // Result still on bus
        read_reg(5'd31);
        end_test();
    endtask

    task automatic test_illegal();
        begin_test("illegal");
        run_instr({11'h000, 9'($urandom), 2'b00, 5'd1, 5'd1}, 1'b1);
        check("illegal", 64'd1, {63'd0, illegal});
        check("data_bus", 64'd0, data_bus);
        check("cw_out enables", 64'd0, {58'd0, enables(cw_out)});  // All disabled
        read_reg(5'd1);
        read_reg(5'd6);
        end_test();
    endtask

    task automatic test_no_valid();
        begin_test("no_valid");
        run_instr(encode_i(cpu_isa_pkg::OP_ADDI, ~model[1][11:0], 5'd31, 5'd1), 1'b0);
        run_instr(encode_d(cpu_isa_pkg::OP_STUR, store_off, 5'd13, 5'd9), 1'b0);
        run_instr(encode_i(cpu_isa_pkg::OP_SUBIS, 12'd1, 5'd31, 5'd31), 1'b0);  // Would set n
        read_reg(5'd1);
        check("status", {60'd0, exp_status}, {60'd0, status});
        run_instr(encode_d(cpu_isa_pkg::OP_LDUR, store_off, 5'd13, 5'd15), 1'b1);
        check("load data_bus", model[6], data_bus);                              // Word kept
        model[15] = model[6];
        end_test();
    endtask

    initial begin
        int polls;
        instr       = '0;
        instr_valid = 1'b0;
        exp_status  = 4'b0000;
        store_off   = '0;
        void'($urandom(32'had57));
        foreach (model[i]) model[i] = '0;   // Registers cleared by reset
        polls = 0;
        while (rst_n !== 1'b1 && polls < 20) begin
            next_negedge();
            polls++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout, reset was never released");
            $display("Simulation failed");
            $finish;
        end
        test_addi();
        test_flags();
        test_logic();
        test_load_store();
        test_zero_reg();
        test_illegal();
        test_no_valid();
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

//--- logic/alu.sv
module alu #(
    parameter int DATA_W = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [DATA_W-1:0]        a,
    input  logic [DATA_W-1:0]        b,
    input  logic [4:0]               fs,
    input  logic                     status_ld,  // Qualified by instr_valid
    output logic [DATA_W-1:0]        f,
    output cpu_control_pkg::status_t status
);

    localparam int SH_W = $clog2(DATA_W);  // 6 bits for 64-bit data

    logic [DATA_W-1:0] a_in;
    logic [DATA_W-1:0] b_in;
    logic              cin;
    logic [DATA_W:0]   sum;    // Carry in the top bit
    cpu_control_pkg::status_t flags;

    assign a_in = fs[0] ? ~a : a;
    assign b_in = fs[1] ? ~b : b;
    assign cin  = fs[1];                   // ~B + 1 gives subtract
    assign sum  = {1'b0, a_in} + {1'b0, b_in} + {{DATA_W{1'b0}}, cin};

    always_comb begin
        case (fs[4:2])
            3'd0:    f = a_in & b_in;
            3'd1:    f = a_in | b_in;
            3'd2:    f = sum[DATA_W-1:0];
            3'd3:    f = a_in ^ b_in;
            3'd4:    f = a_in << b[SH_W-1:0];  // Amount from raw B
            3'd5:    f = a_in >> b[SH_W-1:0];
            default: f = '0;
        endcase
    end

    // Flags from the adder, n and z from the selected result
    assign flags.n = f[DATA_W-1];
    assign flags.z = (f == '0);
    assign flags.c = sum[DATA_W];
    assign flags.v = (a_in[DATA_W-1] == b_in[DATA_W-1]) &&
                     (sum[DATA_W-1] != a_in[DATA_W-1]);  // Same sign in, other out

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else if (status_ld) begin
            status <= flags;
        end
    end

endmodule

//--- logic/control_word_select.sv
module control_word_select (
    input  cpu_isa_pkg::instr_t      instr,
    input  cpu_control_pkg::decode_t d_dec,
    input  cpu_control_pkg::decode_t i_dec,
    output cpu_control_pkg::decode_t dec,
    output logic                     illegal
);

    logic is_d;  // LDUR or STUR
    logic is_i;  // One of the seven immediate ops

    // D-format needs the whole 11-bit opcode
    assign is_d = (instr.op == cpu_isa_pkg::OP_LDUR) ||
                  (instr.op == cpu_isa_pkg::OP_STUR);

    // I-format only owns the upper 10 bits
    assign is_i = instr.op[10:1] inside {
        cpu_isa_pkg::OP_ADDI,
        cpu_isa_pkg::OP_ADDIS,
        cpu_isa_pkg::OP_SUBI,
        cpu_isa_pkg::OP_SUBIS,
        cpu_isa_pkg::OP_ANDI,
        cpu_isa_pkg::OP_ORRI,
        cpu_isa_pkg::OP_EORI
    };

    always_comb begin
        if (is_d) begin
            dec     = d_dec;
            illegal = 1'b0;
        end else if (is_i) begin
            dec     = i_dec;
            illegal = 1'b0;
        end else begin
            // Unknown op, fully disabled word and no constant
            dec.cw  = cpu_control_pkg::CW_NOP;
            dec.k   = '0;
            illegal = 1'b1;
        end
    end

endmodule

//--- logic/cpu_control_pkg.sv
package cpu_control_pkg;

    // 33-bit control word, field order fixed, msb first
    typedef struct packed {
        logic       alu_en;      // ALU result onto data bus
        logic       alu_bs;      // ALU B from K instead of register B
        logic [4:0] alu_fs;      // ALU function select
        logic       rf_b_en;     // Register B onto data bus
        logic [4:0] rf_sa;       // Read port A address
        logic [4:0] rf_sb;       // Read port B address
        logic [4:0] rf_da;       // Write address
        logic       rf_w;        // Register write
        logic       ram_en;      // RAM access
        logic       ram_w;       // RAM write, else read onto bus
        logic       pc_en;       // PC onto data bus, exported only
        logic [1:0] pc_fs;       // PC function, exported only
        logic       pc_is;       // PC input select, exported only
        logic       status_ld;   // Load NZCV
        logic [1:0] next_state;  // Always 0, single-state ISA subset
    } control_word_t;

    // alu_fs: [4:2] function, [1] invert B and carry in, [0] invert A
    // Functions 0 and, 1 or, 2 add, 3 xor, 4 shl, 5 shr, 6/7 zero
    localparam logic [4:0] FS_AND = 5'b000_00;
    localparam logic [4:0] FS_OR  = 5'b001_00;
    localparam logic [4:0] FS_ADD = 5'b010_00;
    localparam logic [4:0] FS_SUB = 5'b010_10;  // A + ~B + 1
    localparam logic [4:0] FS_XOR = 5'b011_00;

    // Nothing enabled, nothing written, bus stays zero
    localparam control_word_t CW_NOP = '{
        alu_en:     1'b0,
        alu_bs:     1'b0,
        alu_fs:     FS_AND,
        rf_b_en:    1'b0,
        rf_sa:      cpu_isa_pkg::ZERO_REG,
        rf_sb:      cpu_isa_pkg::ZERO_REG,
        rf_da:      cpu_isa_pkg::ZERO_REG,
        rf_w:       1'b0,
        ram_en:     1'b0,
        ram_w:      1'b0,
        pc_en:      1'b0,
        pc_fs:      2'b00,
        pc_is:      1'b0,
        status_ld:  1'b0,
        next_state: 2'b00
    };

    typedef struct packed {
        logic n;  // Negative
        logic z;  // Zero
        logic c;  // Carry out
        logic v;  // Signed overflow
    } status_t;

    // Decoder result, control word plus zero-extended constant
    typedef struct packed {
        control_word_t cw;
        logic [63:0]   k;
    } decode_t;

endpackage

//--- logic/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // Register file geometry
    localparam int NUM_REGS = 32;
    localparam logic [4:0] ZERO_REG = 5'd31;  // XZR, hardwired zero

    // D-format and shared field layout, msb first
    // I-format overlays it: imm12 = {op[0], imm9, op2}, rd = rt
    typedef struct packed {
        logic [10:0] op;    // Opcode
        logic [8:0]  imm9;  // D-format address offset
        logic [1:0]  op2;
        logic [4:0]  rn;    // Base or first source
        logic [4:0]  rt;    // Target, also rd for I-format
    } instr_t;

    // D-format opcodes, full 11 bits
    // Bit 1 set means load
    localparam logic [10:0] OP_LDUR = 11'b111_1100_0010;
    localparam logic [10:0] OP_STUR = 11'b111_1100_0000;

    // I-format opcodes, 10-bit prefixes matched against op[10:1]
    // op[0] is the top bit of imm12 there
    localparam logic [9:0] OP_ADDI  = 10'b10_0100_0100;
    localparam logic [9:0] OP_ADDIS = 10'b10_1100_0100;
    localparam logic [9:0] OP_SUBI  = 10'b11_0100_0100;
    localparam logic [9:0] OP_SUBIS = 10'b11_1100_0100;
    localparam logic [9:0] OP_ANDI  = 10'b10_0100_1000;
    localparam logic [9:0] OP_ORRI  = 10'b10_1100_1000;
    localparam logic [9:0] OP_EORI  = 10'b11_0100_1000;

endpackage

//--- logic/d_format_decoder.sv
module d_format_decoder (
    input  cpu_isa_pkg::instr_t      instr,
    output cpu_control_pkg::decode_t dec
);

    logic is_load;  // op[1] set for LDUR, clear for STUR

    assign is_load = instr.op[1];
    // op[10] would pick byte size, only 64-bit accesses exist here

    always_comb begin
        // Address is always Rn + K, result stays off the bus
        dec.cw.alu_en  = 1'b0;
        dec.cw.alu_bs  = 1'b1;                        // B from K
        dec.cw.alu_fs  = cpu_control_pkg::FS_ADD;

        // Store puts Rt on the bus via port B
        dec.cw.rf_b_en = ~is_load;
        dec.cw.rf_sa   = instr.rn;                    // Base register
        dec.cw.rf_sb   = instr.rt;                    // Store data source
        dec.cw.rf_da   = instr.rt;                    // Load target

        // Load writes bus back into Rt
        dec.cw.rf_w    = is_load;

        // RAM in both cases, direction from op
        dec.cw.ram_en  = 1'b1;
        dec.cw.ram_w   = ~is_load;

        // PC fields just advance by 4
        dec.cw.pc_en      = 1'b0;
        dec.cw.pc_fs      = 2'b01;                    // PC + 4
        dec.cw.pc_is      = 1'b0;
        dec.cw.status_ld  = 1'b0;                     // Loads and stores keep flags
        dec.cw.next_state = 2'b00;

        // imm9 offset, zero extended
        dec.k = {55'b0, instr.imm9};
    end

endmodule

//--- logic/data_bus_unit.sv
module data_bus_unit #(
    parameter int DATA_W    = 64,
    parameter int RAM_WORDS = 64
) (
    input  logic              clk,
    input  logic [DATA_W-1:0] addr,     // Byte address from ALU
    input  logic [DATA_W-1:0] alu_f,
    input  logic [DATA_W-1:0] rf_b,
    input  logic              alu_en,
    input  logic              rf_b_en,
    input  logic              ram_en,
    input  logic              ram_w,    // Qualified by instr_valid
    output logic [DATA_W-1:0] bus
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [AW-1:0]     idx;             // 8-byte word index, wraps
    logic [DATA_W-1:0] rd_data;

    assign idx     = addr[AW+2:3];
    assign rd_data = mem[idx];          // Asynchronous read

    // One source at a time, zero when idle
    always_comb begin
        if (alu_en)                bus = alu_f;
        else if (rf_b_en)          bus = rf_b;
        else if (ram_en && !ram_w) bus = rd_data;
        else                       bus = '0;
    end

    // Store takes whatever is on the bus
    always_ff @(posedge clk) begin
        if (ram_en && ram_w) mem[idx] <= bus;
    end

endmodule

//--- logic/datapath_core.sv
module datapath_core #(
    parameter int DATA_W    = 64,
    parameter int RAM_WORDS = 64
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cpu_isa_pkg::instr_t            instr,
    input  logic                           instr_valid,
    output logic [DATA_W-1:0]              data_bus,
    output cpu_control_pkg::status_t       status,
    output logic                           illegal,
    output cpu_control_pkg::control_word_t cw_out
);

    cpu_control_pkg::decode_t      d_dec;   // Load/store view
    cpu_control_pkg::decode_t      i_dec;   // Immediate ALU view
    cpu_control_pkg::decode_t      dec;     // Selected
    cpu_control_pkg::control_word_t cw;

    logic [DATA_W-1:0] rf_a;
    logic [DATA_W-1:0] rf_b;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_f;

    // Write strobes only count on a valid cycle
    logic rf_w_q;
    logic ram_w_q;
    logic status_ld_q;

    d_format_decoder i_d_format_decoder (
        .instr (instr),
        .dec   (d_dec)
    );

    i_format_decoder i_i_format_decoder (
        .instr (instr),
        .dec   (i_dec)
    );

    control_word_select i_control_word_select (
        .instr   (instr),
        .d_dec   (d_dec),
        .i_dec   (i_dec),
        .dec     (dec),
        .illegal (illegal)
    );

    assign cw          = dec.cw;
    assign cw_out      = cw;                       // Ungated, PC fields ride along
    assign rf_w_q      = cw.rf_w & instr_valid;
    assign ram_w_q     = cw.ram_w & instr_valid;
    assign status_ld_q = cw.status_ld & instr_valid;
    assign alu_b       = cw.alu_bs ? dec.k[DATA_W-1:0] : rf_b;  // K or register B

    register_file #(.DATA_W(DATA_W)) i_register_file (
        .clk   (clk),
        .rst_n (rst_n),
        .sa    (cw.rf_sa),
        .sb    (cw.rf_sb),
        .da    (cw.rf_da),
        .w     (rf_w_q),
        .d     (data_bus),                         // Write back from bus
        .a     (rf_a),
        .b     (rf_b)
    );

    alu #(.DATA_W(DATA_W)) i_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (rf_a),
        .b         (alu_b),
        .fs        (cw.alu_fs),
        .status_ld (status_ld_q),
        .f         (alu_f),
        .status    (status)
    );

    // ALU result doubles as the memory address
    data_bus_unit #(
        .DATA_W    (DATA_W),
        .RAM_WORDS (RAM_WORDS)
    ) i_data_bus_unit (
        .clk     (clk),
        .addr    (alu_f),
        .alu_f   (alu_f),
        .rf_b    (rf_b),
        .alu_en  (cw.alu_en),
        .rf_b_en (cw.rf_b_en),
        .ram_en  (cw.ram_en),
        .ram_w   (ram_w_q),
        .bus     (data_bus)
    );

endmodule

//--- logic/i_format_decoder.sv
module i_format_decoder (
    input  cpu_isa_pkg::instr_t      instr,
    output cpu_control_pkg::decode_t dec
);

    logic [4:0]  fs;       // Function for this opcode
    logic        set_flags;
    logic [11:0] imm12;

    // imm12 straddles op[0], imm9 and op2
    assign imm12 = {instr.op[0], instr.imm9, instr.op2};

    // Opcode to ALU function, flags only for the S forms
    always_comb begin
        fs        = cpu_control_pkg::FS_ADD;
        set_flags = 1'b0;
        case (instr.op[10:1])
            cpu_isa_pkg::OP_ADDI:  fs = cpu_control_pkg::FS_ADD;
            cpu_isa_pkg::OP_ADDIS: begin
                fs        = cpu_control_pkg::FS_ADD;
                set_flags = 1'b1;
            end
            cpu_isa_pkg::OP_SUBI:  fs = cpu_control_pkg::FS_SUB;
            cpu_isa_pkg::OP_SUBIS: begin
                fs        = cpu_control_pkg::FS_SUB;
                set_flags = 1'b1;
            end
            cpu_isa_pkg::OP_ANDI:  fs = cpu_control_pkg::FS_AND;
            cpu_isa_pkg::OP_ORRI:  fs = cpu_control_pkg::FS_OR;
            cpu_isa_pkg::OP_EORI:  fs = cpu_control_pkg::FS_XOR;
            default:               fs = cpu_control_pkg::FS_ADD;  // Selector drops it anyway
        endcase
    end

    always_comb begin
        dec.cw.alu_en  = 1'b1;                        // Result onto bus
        dec.cw.alu_bs  = 1'b1;                        // Second operand is K
        dec.cw.alu_fs  = fs;
        dec.cw.rf_b_en = 1'b0;
        dec.cw.rf_sa   = instr.rn;
        dec.cw.rf_sb   = cpu_isa_pkg::ZERO_REG;       // Port B unused
        dec.cw.rf_da   = instr.rt;                    // Rd shares the Rt slot
        dec.cw.rf_w    = 1'b1;
        dec.cw.ram_en  = 1'b0;
        dec.cw.ram_w   = 1'b0;

        dec.cw.pc_en      = 1'b0;
        dec.cw.pc_fs      = 2'b01;                    // PC + 4
        dec.cw.pc_is      = 1'b0;
        dec.cw.status_ld  = set_flags;
        dec.cw.next_state = 2'b00;

        dec.k = {52'b0, imm12};                       // Zero extended
    end

endmodule

//--- logic/register_file.sv
module register_file #(
    parameter int DATA_W = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [4:0]        sa,  // Read address A
    input  logic [4:0]        sb,  // Read address B
    input  logic [4:0]        da,  // Write address
    input  logic              w,   // Write enable, already qualified
    input  logic [DATA_W-1:0] d,   // Write data from bus
    output logic [DATA_W-1:0] a,
    output logic [DATA_W-1:0] b
);

    logic [DATA_W-1:0] regs [cpu_isa_pkg::NUM_REGS];

    // Synchronous clear of all registers
    // Writes to XZR are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (w && (da != cpu_isa_pkg::ZERO_REG)) begin
            regs[da] <= d;
        end
    end

    // Both ports combinational, XZR masked to zero
    assign a = (sa == cpu_isa_pkg::ZERO_REG) ? '0 : regs[sa];
    assign b = (sb == cpu_isa_pkg::ZERO_REG) ? '0 : regs[sb];

endmodule

//--- run.sh
#!/bin/sh
# Verilator build and run, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

if ! verilator --binary --timing --assert -f all.f --top-module tb_datapath_core; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_datapath_core > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1
